// ==== hw/ex_stage_pkg.sv ====
package ex_stage_pkg;

    typedef logic [31:0] word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU and decode encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_eq      // equality compare for beq and bne
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_12i,    // sign-extended 12 bits
        imm_20u,    // upper 20 bits, low 12 cleared
        imm_20j,    // jump offset, sign-extended and doubled
        imm_5u      // zero-extended shift amount
    } imm_sel_e;

    typedef enum logic [1:0] {rs1_reg, rs1_pc, rs1_zero} rs1_sel_e;

    typedef enum logic [1:0] {hs_idle, hs_exec, hs_done} hs_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32I major opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_branch = 7'b1100011;

endpackage

// ==== hw/ex_op_if.sv ====
`timescale 1ns/10ps

interface ex_op_if import ex_stage_pkg::*; ();

    word_t instr;
    word_t pc;
    word_t rs1_value;
    word_t rs2_value;

    modport ctrl (output instr, pc, rs1_value, rs2_value);

    // the decoder only looks at the instruction word
    modport dec (input instr);

    modport exu (input pc, rs1_value, rs2_value);

endinterface

// ==== hw/ex_ctrl_if.sv ====
`timescale 1ns/10ps

interface ex_ctrl_if import ex_stage_pkg::*; ();

    alu_op_e  alu_op;
    imm_sel_e imm_sel;
    word_t    imm_raw;  // immediate bits already put back in order by the decoder
    rs1_sel_e rs1_sel;
    logic     rs2_reg;  // high selects rs2, low the immediate
    logic     inv;

    modport dec (
        output alu_op, imm_sel, imm_raw, rs1_sel, rs2_reg, inv
    );

    modport exu (
        input alu_op, imm_sel, imm_raw, rs1_sel, rs2_reg, inv
    );

endinterface

// ==== hw/req_ack_ctrl.sv ====
`timescale 1ns/10ps

module req_ack_ctrl import ex_stage_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req,
    output logic       ack,
    input  word_t      instr,
    input  word_t      pc,
    input  word_t      rs1_value,
    input  word_t      rs2_value,
    ex_op_if.ctrl      op,
    input  word_t      exu_result,
    input  logic       illegal_in,
    output word_t      result,
    output logic       illegal
);

    hs_state_e state;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // four-phase handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= hs_idle;
            ack     <= 1'b0;
            result  <= '0;
            illegal <= 1'b0;
        end else begin
            case (state)
                hs_idle: begin
                    if (req) state <= hs_exec;  // operands are captured on this edge
                end
                hs_exec: begin
                    // decode and execute have settled from the captured operands
                    state   <= hs_done;
                    ack     <= 1'b1;
                    result  <= exu_result;
                    illegal <= illegal_in;
                end
                hs_done: begin
                    if (!req) begin
                        state <= hs_idle;
                        ack   <= 1'b0;
                    end
                end
                default: state <= hs_idle;
            endcase
        end
    end

    // the requester holds its inputs until ack, so one capture per transaction is enough
    always_ff @(posedge clk) begin
        if (state == hs_idle && req) begin
            op.instr     <= instr;
            op.pc        <= pc;
            op.rs1_value <= rs1_value;
            op.rs2_value <= rs2_value;
        end
    end

endmodule

// ==== hw/idu.sv ====
`timescale 1ns/10ps

module idu import ex_stage_pkg::*; (
    ex_op_if.dec   op,
    ex_ctrl_if.dec ctrl,
    output logic   illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;     // funct7 of sub and sra

    assign opcode  = op.instr[6:0];
    assign funct3  = op.instr[14:12];
    assign f7_zero = (op.instr[31:25] == 7'b0000000);
    assign f7_alt  = (op.instr[31:25] == 7'b0100000);

    // funct3 mapping shared by OP and OP-IMM
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e sel;
        case (f3)
            3'b000:  sel = alt ? alu_sub : alu_add;
            3'b001:  sel = alu_sll;
            3'b010:  sel = alu_slt;
            3'b011:  sel = alu_sltu;
            3'b100:  sel = alu_xor;
            3'b101:  sel = alt ? alu_sra : alu_srl;
            3'b110:  sel = alu_or;
            default: sel = alu_and;
        endcase
        return sel;
    endfunction

    always_comb begin
        ctrl.alu_op  = alu_add;
        ctrl.imm_sel = imm_12i;
        ctrl.imm_raw = '0;
        ctrl.rs1_sel = rs1_reg;
        ctrl.rs2_reg = 1'b0;
        ctrl.inv     = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            opc_op: begin
                ctrl.alu_op  = arith_op(funct3, f7_alt);
                ctrl.rs2_reg = 1'b1;
                illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            opc_op_imm: begin
                ctrl.imm_raw = {20'd0, op.instr[31:20]};
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.alu_op  = arith_op(funct3, f7_alt);
                    ctrl.imm_sel = imm_5u;      // shamt sits in the low five immediate bits
                    illegal = !(f7_zero || (f7_alt && funct3 == 3'b101));
                end else begin
                    ctrl.alu_op = arith_op(funct3, 1'b0);   // bit 30 belongs to the immediate
                end
            end
            opc_lui, opc_auipc: begin
                ctrl.imm_sel = imm_20u;
                ctrl.imm_raw = {12'd0, op.instr[31:12]};
                ctrl.rs1_sel = (opcode == opc_lui) ? rs1_zero : rs1_pc;
            end
            opc_jal: begin
                // offset bits 20:1 back in their natural order
                ctrl.imm_sel = imm_20j;
                ctrl.imm_raw = {12'd0, op.instr[31], op.instr[19:12], op.instr[20],
                                op.instr[30:21]};
                ctrl.rs1_sel = rs1_pc;
            end
            opc_branch: begin
                ctrl.rs2_reg = 1'b1;
                ctrl.inv     = funct3[0];   // bne, bge and bgeu negate their base compare
                case (funct3[2:1])
                    2'b00:   ctrl.alu_op = alu_eq;
                    2'b10:   ctrl.alu_op = alu_slt;
                    2'b11:   ctrl.alu_op = alu_sltu;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        // an unsupported instruction returns zero
        if (illegal) begin
            ctrl.alu_op  = alu_and;
            ctrl.rs1_sel = rs1_zero;
            ctrl.inv     = 1'b0;
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/10ps

module imm_gen import ex_stage_pkg::*; (
    input  word_t    imm_raw,
    input  imm_sel_e imm_sel,
    output word_t    imm
);

    always_comb begin
        case (imm_sel)
            imm_12i: begin
                imm = {{20{imm_raw[11]}}, imm_raw[11:0]};
            end
            imm_20u: begin
                imm = {imm_raw[19:0], 12'd0};
            end
            imm_20j: begin
                // bit 0 of a jump offset is always zero
                imm = {{11{imm_raw[19]}}, imm_raw[19:0], 1'b0};
            end
            imm_5u: begin
                imm = {27'd0, imm_raw[4:0]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu import ex_stage_pkg::*; #(
    parameter int alu_width = 32
) (
    input  logic [alu_width-1:0] d1,
    input  logic [alu_width-1:0] d2,
    input  alu_op_e              op,
    output logic [alu_width-1:0] res
);

    localparam int sh_width = $clog2(alu_width);

    logic [sh_width-1:0] shamt;
    logic                lt_signed;
    logic                lt_unsigned;
    logic                equal;

    assign shamt = d2[sh_width-1:0];   // upper bits of the shift operand are ignored

    assign lt_signed   = ($signed(d1) < $signed(d2));
    assign lt_unsigned = (d1 < d2);
    assign equal       = (d1 == d2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        res = '0;
        case (op)
            alu_add: begin
                res = d1 + d2;
            end
            alu_sub: begin
                res = d1 - d2;
            end
            alu_sll: begin
                res = d1 << shamt;
            end
            alu_srl: begin
                res = d1 >> shamt;
            end
            alu_sra: begin
                res = $signed(d1) >>> shamt;
            end
            alu_xor: begin
                res = d1 ^ d2;
            end
            alu_or: begin
                res = d1 | d2;
            end
            alu_and: begin
                res = d1 & d2;
            end
            // compares leave the upper bits clear
            alu_slt: begin
                res[0] = lt_signed;
            end
            alu_sltu: begin
                res[0] = lt_unsigned;
            end
            alu_eq: begin
                res[0] = equal;
            end
            default: begin
                res = '0;
            end
        endcase
    end

endmodule

// ==== hw/exu.sv ====
`timescale 1ns/10ps

module exu import ex_stage_pkg::*; #(
    parameter int alu_width = 32
) (
    ex_op_if.exu   op,
    ex_ctrl_if.exu ctrl,
    output word_t  result
);

    word_t                imm;
    word_t                opnd1;
    word_t                opnd2;
    logic [alu_width-1:0] alu_res;

    imm_gen u_imm_gen (
        .imm_raw (ctrl.imm_raw),
        .imm_sel (ctrl.imm_sel),
        .imm     (imm)
    );

    always_comb begin
        case (ctrl.rs1_sel)
            rs1_reg: opnd1 = op.rs1_value;
            rs1_pc:  opnd1 = op.pc;      // auipc and jal add to the pc
            default: opnd1 = '0;
        endcase
    end

    assign opnd2 = ctrl.rs2_reg ? op.rs2_value : imm;

    alu #(
        .alu_width (alu_width)
    ) u_alu (
        .d1  (alu_width'(opnd1)),
        .d2  (alu_width'(opnd2)),
        .op  (ctrl.alu_op),
        .res (alu_res)
    );

    // inv only ever flips a compare bit
    assign result = word_t'(alu_res) ^ {31'd0, ctrl.inv};

endmodule

// ==== hw/ex_stage_top.sv ====
`timescale 1ns/10ps

module ex_stage_top import ex_stage_pkg::*; #(
    parameter int alu_width = 32
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req,
    output logic  ack,
    input  word_t instr,
    input  word_t pc,
    input  word_t rs1_value,
    input  word_t rs2_value,
    output word_t result,
    output logic  illegal
);

    word_t exu_result;
    logic  dec_illegal;

    ex_op_if   op_if ();
    ex_ctrl_if ctrl_if ();

    req_ack_ctrl u_req_ack_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ack        (ack),
        .instr      (instr),
        .pc         (pc),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .op         (op_if.ctrl),
        .exu_result (exu_result),
        .illegal_in (dec_illegal),
        .result     (result),
        .illegal    (illegal)
    );

    idu u_idu (
        .op      (op_if.dec),
        .ctrl    (ctrl_if.dec),
        .illegal (dec_illegal)
    );

    exu #(
        .alu_width (alu_width)
    ) u_exu (
        .op     (op_if.exu),
        .ctrl   (ctrl_if.exu),
        .result (exu_result)
    );

endmodule

// ==== tests/ex_stage_sva.sv ====
`timescale 1ns/10ps

module ex_stage_sva import ex_stage_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  req,
    input logic  ack,
    input word_t result,
    input logic  illegal
);

    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // four-phase handshake rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
        else begin
            fail_count++;
            $error("ack not low after reset");
        end

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req)
        else begin
            fail_count++;
            $error("ack rose without req");
        end

    // the stage may only drop ack once req has gone low
    ack_held_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack && req |=> ack)
        else begin
            fail_count++;
            $error("ack dropped while req still high");
        end

    outputs_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> (!ack || ($stable(result) && $stable(illegal))))
        else begin
            fail_count++;
            $error("result or illegal changed while ack high");
        end

endmodule

bind req_ack_ctrl ex_stage_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .result  (result),
    .illegal (illegal)
);

// ==== tests/ex_stage_tb.sv ====
`timescale 1ns/10ps

module ex_stage_tb import ex_stage_pkg::*; ();

    typedef struct {
        word_t instr;
        word_t pc;
        word_t rs1;
        word_t rs2;
        word_t exp;
        logic  ill;
    } vec_t;

    localparam int n_random = 20;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  req;
    logic  ack;
    word_t instr;
    word_t pc;
    word_t rs1_value;
    word_t rs2_value;
    word_t result;
    logic  illegal;

    vec_t  vectors[$];
    int    cycles = 0;
    int    cycle_limit = 1000;

    ex_stage_top #(.alu_width(32)) u_dut (.*);

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders and table fill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc_op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, opc_op_imm};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [6:0] opc);
        return {imm, 5'd3, opc};
    endfunction

    function automatic word_t enc_j(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, opc_jal};
    endfunction

    function automatic word_t enc_b(logic [2:0] f3);
        return {7'd0, 5'd2, 5'd1, f3, 5'd0, opc_branch};  // branch offset plays no part here
    endfunction

    function automatic void add_vec(word_t i, word_t p, word_t a, word_t b, word_t e, logic il);
        vec_t v;
        v.instr = i;
        v.pc    = p;
        v.rs1   = a;
        v.rs2   = b;
        v.exp   = e;
        v.ill   = il;
        vectors.push_back(v);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks and handshake driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_now(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_result(word_t got, word_t exp, string msg);
        if (got !== exp) fail_now($sformatf("%s result %h expected %h", msg, got, exp));
    endtask

    task automatic check_illegal(logic got, logic exp, string msg);
        if (got !== exp) fail_now($sformatf("%s illegal %b expected %b", msg, got, exp));
    endtask

    task automatic run_txn(vec_t v, int hold, string name);
        int edges;
        edges = 0;
        @(posedge clk);
        req       <= 1'b1;
        instr     <= v.instr;
        pc        <= v.pc;
        rs1_value <= v.rs1;
        rs2_value <= v.rs2;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (edges > 20) fail_now({name, " ack never rose"});
        end while (!ack);
        if (edges != 2) fail_now($sformatf("%s ack after %0d edges, expected 2", name, edges));
        check_result(result, v.exp, name);
        check_illegal(illegal, v.ill, name);
        repeat (hold) begin
            @(negedge clk);
            if (!ack) fail_now({name, " ack dropped while req held"});
            check_result(result, v.exp, {name, " hold"});
            check_illegal(illegal, v.ill, {name, " hold"});
        end
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
            if (edges > 20) fail_now({name, " ack never fell"});
        end while (ack);
        if (edges != 2) begin
            fail_now($sformatf("%s ack fell after %0d edges, expected 2", name, edges));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the handshake stopped making progress", cycles);
            $display("CHECKS FAILED");
            $fatal(1, "run aborted");
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_req_ack_ctrl.u_sva.fail_count != 0) begin
            $display("a handshake assertion failed before %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1, "run aborted");
        end
    end

    initial begin
        vec_t  v;
        word_t a;
        word_t b;
        void'($urandom(76));
        rst_n     <= 1'b0;
        req       <= 1'b0;
        instr     <= '0;
        pc        <= '0;
        rs1_value <= '0;
        rs2_value <= '0;

        add_vec(enc_r(7'h00, 3'b000), 0, 5, 7, 32'd12, 0);                         // add
        add_vec(enc_r(7'h20, 3'b000), 0, 5, 7, 32'hFFFFFFFE, 0);                   // sub
        add_vec(enc_r(7'h00, 3'b001), 0, 1, 32'h24, 32'h10, 0);                    // sll
        add_vec(enc_r(7'h00, 3'b010), 0, 32'hFFFFFFFF, 1, 1, 0);                   // slt
        add_vec(enc_r(7'h00, 3'b011), 0, 32'hFFFFFFFF, 1, 0, 0);                   // sltu
        add_vec(enc_r(7'h00, 3'b100), 0, 32'hF0F0F0F0, 32'hFF00FF00, 32'h0FF00FF0, 0);
        add_vec(enc_r(7'h00, 3'b101), 0, 32'h80000000, 4, 32'h08000000, 0);        // srl
        add_vec(enc_r(7'h20, 3'b101), 0, 32'h80000000, 4, 32'hF8000000, 0);        // sra
        add_vec(enc_r(7'h00, 3'b110), 0, 32'hF0F0F0F0, 32'h0F0F0000, 32'hFFFFF0F0, 0);
        add_vec(enc_r(7'h00, 3'b111), 0, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 0);
        add_vec(enc_i(12'hFFF, 3'b000), 0, 10, 0, 9, 0);                           // addi -1
        add_vec(enc_i(12'h005, 3'b010), 0, 32'hFFFFFFFB, 0, 1, 0);                 // slti
        add_vec(enc_i(12'hFFF, 3'b011), 0, 5, 0, 1, 0);                            // sltiu
        add_vec(enc_i(12'h0FF, 3'b100), 0, 32'h12345678, 0, 32'h12345687, 0);
        add_vec(enc_i(12'h800, 3'b110), 0, 1, 0, 32'hFFFFF801, 0);                 // ori
        add_vec(enc_i(12'h0F0, 3'b111), 0, 32'h12345678, 0, 32'h70, 0);
        add_vec(enc_i(12'h008, 3'b001), 0, 32'h81, 0, 32'h8100, 0);                // slli
        add_vec(enc_i(12'h01F, 3'b101), 0, 32'h80000000, 0, 1, 0);                 // srli
        add_vec(enc_i(12'h41F, 3'b101), 0, 32'h80000000, 0, 32'hFFFFFFFF, 0);      // srai
        add_vec(enc_u(20'hABCDE, opc_lui), 0, 32'h55, 0, 32'hABCDE000, 0);
        add_vec(enc_u(20'h00001, opc_auipc), 32'h100, 0, 0, 32'h1100, 0);
        add_vec(enc_j(21'h000800), 32'h1000, 0, 0, 32'h1800, 0);
        add_vec(enc_j(21'h1FFFFC), 32'h1000, 0, 0, 32'h0FFC, 0);                   // jal -4
        add_vec(enc_b(3'b000), 0, 3, 3, 1, 0);                                     // beq
        add_vec(enc_b(3'b001), 0, 3, 3, 0, 0);                                     // bne
        add_vec(enc_b(3'b100), 0, 32'h80000000, 32'h7FFFFFFF, 1, 0);               // blt
        add_vec(enc_b(3'b101), 0, 32'h80000000, 32'h7FFFFFFF, 0, 0);               // bge
        add_vec(enc_b(3'b110), 0, 32'h80000000, 32'h7FFFFFFF, 0, 0);               // bltu
        add_vec(enc_b(3'b111), 0, 32'h80000000, 32'h7FFFFFFF, 1, 0);               // bgeu
        add_vec(enc_b(3'b101), 0, 32'hFFFFFFFF, 32'hFFFFFFFF, 1, 0);
        add_vec(enc_b(3'b110), 0, 0, 32'hFFFFFFFF, 1, 0);
        add_vec(32'h0000_A183, 0, 4, 5, 0, 1);                                     // load opcode
        add_vec(enc_r(7'h01, 3'b000), 0, 4, 5, 0, 1);                              // mul funct7
        add_vec(enc_r(7'h00, 3'b000), 0, 1, 1, 2, 0);                              // clears illegal

        cycle_limit = (vectors.size() + n_random) * 10 + 50;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        foreach (vectors[i]) begin
            run_txn(vectors[i], (i % 5 == 0) ? 3 : 0, $sformatf("vector %0d", i));
        end

        // random adds with the expected sum formed here
        for (int i = 0; i < n_random; i++) begin
            a       = $urandom();
            b       = $urandom();
            v.instr = enc_r(7'h00, 3'b000);
            v.pc    = '0;
            v.rs1   = a;
            v.rs2   = b;
            v.exp   = a + b;
            v.ill   = 1'b0;
            run_txn(v, 0, $sformatf("random add %0d", i));
        end

        if (u_dut.u_req_ack_ctrl.u_sva.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("a handshake assertion failed during the run");
            $display("CHECKS FAILED");
            $fatal(1, "run aborted");
        end
    end

endmodule

// ==== ex_stage.f ====
hw/ex_stage_pkg.sv
hw/ex_op_if.sv
hw/ex_ctrl_if.sv
hw/req_ack_ctrl.sv
hw/idu.sv
hw/imm_gen.sv
hw/alu.sv
hw/exu.sv
hw/ex_stage_top.sv
tests/ex_stage_sva.sv
tests/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - hw/ex_stage_pkg.sv
      - hw/ex_op_if.sv
      - hw/ex_ctrl_if.sv
      - hw/req_ack_ctrl.sv
      - hw/idu.sv
      - hw/imm_gen.sv
      - hw/alu.sv
      - hw/exu.sv
      - hw/ex_stage_top.sv
  - target: test
    files:
      - tests/ex_stage_sva.sv
      - tests/ex_stage_tb.sv
